// File: project.f
hw/colorPkg.sv
hw/convCtrlPkg.sv
hw/chromaUpsampler.sv
hw/colorSpaceConverter.sv
hw/frameConvertCtrl.sv
hw/yuvToRgbTop.sv
tb/sramModel.sv
tb/yuvToRgb_assertions.sv
tb/yuvToRgbTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module yuvToRgbTb -f project.f || exit 1
simOutput=$(./obj_dir/VyuvToRgbTb 2>&1)
echo "$simOutput"
echo "$simOutput" | grep -qx "No errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tb/yuvToRgbTb.sv
`timescale 1ns/1ps

module yuvToRgbTb import colorPkg::*, convCtrlPkg::*; ();

	localparam int Width = 8;
	localparam int Height = 2;
	localparam logic [SramAddrWidth-1:0] YBase = 18'h00020;
	localparam logic [SramAddrWidth-1:0] UBase = 18'h00040;
	localparam logic [SramAddrWidth-1:0] VBase = 18'h00050;
	localparam logic [SramAddrWidth-1:0] RgbBase = 18'h00080;
	localparam int PairsPerRow = Width / 2;
	localparam int ChromaPerRow = Width / 2;
	localparam int RgbWords = 3 * PairsPerRow * Height;
	// Lead-in, six cycles per pair and lead-out per row, plus start and done
	localparam int FrameCycles = Height * (8 + 6 * PairsPerRow) + 4;
	localparam int FrameCount = 6;
	localparam int CycleLimit = 4 * FrameCycles * FrameCount;

	logic Clock;
	logic Resetn;
	logic Start;
	logic Busy;
	logic Done;
	logic [SramAddrWidth-1:0] SramAddress;
	logic [SramDataWidth-1:0] SramReadData;
	logic [SramDataWidth-1:0] SramWriteData;
	logic SramWeN;

	logic [7:0] yPix [Height][Width];
	logic [7:0] uSmp [Height][ChromaPerRow];
	logic [7:0] vSmp [Height][ChromaPerRow];
	logic [31:0] rngState;
	int errorCount;
	int donePulses = 0;
	int cycleCount;
	int startCycle;
	int frameLength;

	yuvToRgbTop #(
		.Width(Width),
		.Height(Height),
		.YBase(YBase),
		.UBase(UBase),
		.VBase(VBase),
		.RgbBase(RgbBase)
	) yuvToRgbTop_i (
		.Clock(Clock), .Resetn(Resetn), .Start(Start), .Busy(Busy), .Done(Done),
		.SramAddress(SramAddress), .SramReadData(SramReadData),
		.SramWriteData(SramWriteData), .SramWeN(SramWeN)
	);

	sramModel sramModel_i (
		.Clock(Clock), .Address(SramAddress), .WriteData(SramWriteData),
		.WeN(SramWeN), .ReadData(SramReadData)
	);

	always #20 Clock = ~Clock;

	always @(negedge Clock) begin
		if (Done) begin
			donePulses++;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [7:0] randomByte();
		rngState = xorshift32(rngState);
		return rngState[15:8];
	endfunction

	function automatic logic [7:0] clampByte(input int value);
		if (value < 0) begin
			return 8'd0;
		end else if (value > 255) begin
			return 8'd255;
		end
		return value[7:0];
	endfunction

	// Even chroma sample, row ends replicated
	function automatic int chromaAt(input bit isV, input int row, input int idx);
		int k;
		k = (idx < 0) ? 0 : ((idx > ChromaPerRow - 1) ? ChromaPerRow - 1 : idx);
		return isV ? int'(vSmp[row][k]) : int'(uSmp[row][k]);
	endfunction

	function automatic logic [7:0] oddChroma(input bit isV, input int row, input int pair);
		int c [6];
		int sum;
		for (int i = 0; i < 6; i++) begin
			c[i] = chromaAt(isV, row, pair - 2 + i);
		end
		sum = FirTapFar * (c[0] + c[5]) - FirTapMid * (c[1] + c[4])
			+ FirTapNear * (c[2] + c[3]) + FirRound;
		return clampByte(sum >>> 8);
	endfunction

	// Packed as R, G, B
	function automatic logic [23:0] pixelRgb(input logic [7:0] y, input logic [7:0] u,
		input logic [7:0] v);
		int yTerm;
		int uTerm;
		int vTerm;
		yTerm = CoefY * (int'(y) - LumaOffset);
		uTerm = int'(u) - ChromaOffset;
		vTerm = int'(v) - ChromaOffset;
		return {clampByte((yTerm + CoefRV * vTerm) >>> 16),
			clampByte((yTerm - CoefGU * uTerm - CoefGV * vTerm) >>> 16),
			clampByte((yTerm + CoefBU * uTerm) >>> 16)};
	endfunction

	function automatic logic [15:0] expectedWord(input int row, input int pair, input int slot);
		logic [23:0] even;
		logic [23:0] odd;
		logic [15:0] word;
		even = pixelRgb(yPix[row][2 * pair], uSmp[row][pair], vSmp[row][pair]);
		odd = pixelRgb(yPix[row][2 * pair + 1], oddChroma(1'b0, row, pair),
			oddChroma(1'b1, row, pair));
		case (slot)
			0: word = {even[23:16], even[15:8]};
			1: word = {even[7:0], odd[23:16]};
			default: word = {odd[15:8], odd[7:0]};
		endcase
		return word;
	endfunction

	function automatic logic [15:0] fillWord(input logic [SramAddrWidth-1:0] addr);
		return addr[15:0] ^ {addr[1:0], addr[17:4]} ^ 16'hb5a3;
	endfunction

	task automatic checkLevel(input string signal, input logic got, input logic want);
		assert (got == want) else begin
			errorCount++;
			$display("ERROR %s is %h, expected %h", signal, got, want);
		end
	endtask

	task automatic checkMasked(input string test, input logic [SramAddrWidth-1:0] addr,
		input logic [15:0] mask, input logic [15:0] want);
		logic [15:0] got;
		got = sramModel_i.memory[addr] & mask;
		assert (got == want) else begin
			errorCount++;
			$display("ERROR %s: SramWriteData at %h masked %h is %h, expected %h",
				test, addr, mask, got, want);
		end
	endtask

	task automatic fillRandom();
		for (int r = 0; r < Height; r++) begin
			for (int x = 0; x < Width; x++) begin
				yPix[r][x] = randomByte();
			end
			for (int k = 0; k < ChromaPerRow; k++) begin
				uSmp[r][k] = randomByte();
				vSmp[r][k] = randomByte();
			end
		end
	endtask

	task automatic loadFrame();
		logic [SramAddrWidth-1:0] addr;
		for (int r = 0; r < Height; r++) begin
			for (int k = 0; k < Width / 2; k++) begin
				addr = YBase + SramAddrWidth'(r * Width / 2 + k);
				sramModel_i.memory[addr] = {yPix[r][2 * k], yPix[r][2 * k + 1]};
			end
			for (int k = 0; k < Width / 4; k++) begin
				addr = UBase + SramAddrWidth'(r * Width / 4 + k);
				sramModel_i.memory[addr] = {uSmp[r][2 * k], uSmp[r][2 * k + 1]};
				addr = VBase + SramAddrWidth'(r * Width / 4 + k);
				sramModel_i.memory[addr] = {vSmp[r][2 * k], vSmp[r][2 * k + 1]};
			end
		end
		// Old RGB words must not survive into the next frame
		for (int a = 0; a < RgbWords; a++) begin
			addr = RgbBase + SramAddrWidth'(a);
			sramModel_i.memory[addr] = fillWord(addr);
		end
	endtask

	task automatic pulseStart();
		@(posedge Clock);
		#1 Start = 1'b1;
		@(posedge Clock);
		#1 Start = 1'b0;
		startCycle = cycleCount;
	endtask

	task automatic waitFrameEnd(input string test, input int donesBefore);
		int waited;
		waited = 0;
		while (!Done && waited < 2 * FrameCycles) begin
			@(negedge Clock);
			waited++;
		end
		frameLength = cycleCount - startCycle;
		assert (Done) else begin
			errorCount++;
			$display("%s: Done did not pulse within %0d cycles of Start", test, 2 * FrameCycles);
		end
		repeat (2) @(negedge Clock);
		assert (donePulses == donesBefore + 1) else begin
			errorCount++;
			$display("ERROR %s: Done pulses %h, expected %h", test,
				donePulses - donesBefore, 1);
		end
	endtask

	task automatic runFrame(input string test);
		int donesBefore;
		donesBefore = donePulses;
		pulseStart();
		waitFrameEnd(test, donesBefore);
	endtask

	task automatic compareFrame(input string test);
		logic [SramAddrWidth-1:0] addr;
		for (int r = 0; r < Height; r++) begin
			for (int p = 0; p < PairsPerRow; p++) begin
				for (int s = 0; s < 3; s++) begin
					addr = RgbBase + SramAddrWidth'(3 * (r * PairsPerRow + p) + s);
					checkMasked(test, addr, 16'hffff, expectedWord(r, p, s));
				end
			end
		end
	endtask

	task automatic checkIdleAfterReset();
		@(negedge Clock);
		checkLevel("Busy", Busy, 1'b0);
		checkLevel("Done", Done, 1'b0);
		repeat (8) begin
			checkLevel("SramWeN", SramWeN, 1'b1);
			@(negedge Clock);
		end
	endtask

	task automatic testFlatGrey();
		logic [7:0] grey;
		grey = clampByte((CoefY * (128 - LumaOffset)) >>> 16);
		for (int r = 0; r < Height; r++) begin
			for (int x = 0; x < Width; x++) begin
				yPix[r][x] = 8'd128;
			end
			for (int k = 0; k < ChromaPerRow; k++) begin
				uSmp[r][k] = 8'd128;
				vSmp[r][k] = 8'd128;
			end
		end
		loadFrame();
		runFrame("grey");
		for (int a = 0; a < RgbWords; a++) begin
			checkMasked("grey", RgbBase + SramAddrWidth'(a), 16'hffff, {grey, grey});
		end
	endtask

	task automatic testRandomFrame();
		fillRandom();
		loadFrame();
		runFrame("random");
		compareFrame("random");
	endtask

	task automatic testRowEdges();
		fillRandom();
		// Opposite extremes at the two ends of each chroma row
		for (int r = 0; r < Height; r++) begin
			uSmp[r][0] = (r == 0) ? 8'd5 : 8'd250;
			uSmp[r][ChromaPerRow - 1] = (r == 0) ? 8'd250 : 8'd5;
			vSmp[r][0] = (r == 0) ? 8'd240 : 8'd12;
			vSmp[r][ChromaPerRow - 1] = (r == 0) ? 8'd12 : 8'd240;
		end
		loadFrame();
		runFrame("row edges");
		compareFrame("row edges");
	endtask

	task automatic testExtremes();
		logic [SramAddrWidth-1:0] addr;
		for (int x = 0; x < Width; x++) begin
			yPix[0][x] = 8'd255;
			yPix[1][x] = 8'd0;
		end
		for (int k = 0; k < ChromaPerRow; k++) begin
			uSmp[0][k] = 8'd128;
			vSmp[0][k] = 8'd255;
			uSmp[1][k] = 8'd0;
			vSmp[1][k] = 8'd128;
		end
		loadFrame();
		runFrame("extremes");
		compareFrame("extremes");
		// Red and blue saturate high in row 0 and low in row 1
		for (int p = 0; p < PairsPerRow; p++) begin
			addr = RgbBase + SramAddrWidth'(3 * p);
			checkMasked("extremes", addr, 16'hff00, 16'hff00);
			checkMasked("extremes", addr + 18'd1, 16'hffff, 16'hffff);
			checkMasked("extremes", addr + 18'd2, 16'h00ff, 16'h00ff);
			addr = RgbBase + SramAddrWidth'(3 * (PairsPerRow + p));
			checkMasked("extremes", addr, 16'hff00, 16'h0000);
			checkMasked("extremes", addr + 18'd1, 16'hffff, 16'h0000);
			checkMasked("extremes", addr + 18'd2, 16'h00ff, 16'h0000);
		end
	endtask

	task automatic testStartWhileBusy();
		int donesBefore;
		int busyFrameLength;
		fillRandom();
		loadFrame();
		donesBefore = donePulses;
		pulseStart();
		repeat (5) @(posedge Clock);
		#1 Start = 1'b1;
		checkLevel("Busy", Busy, 1'b1);
		@(posedge Clock);
		#1 Start = 1'b0;
		waitFrameEnd("start while busy", donesBefore);
		busyFrameLength = frameLength;
		compareFrame("start while busy");
		repeat (3) begin
			@(negedge Clock);
			checkLevel("Busy", Busy, 1'b0);
		end
		fillRandom();
		loadFrame();
		runFrame("second frame");
		compareFrame("second frame");
		// A Start during a frame must not stretch it
		assert (busyFrameLength == frameLength) else begin
			errorCount++;
			$display("Start while busy changed the frame length from %0d to %0d cycles",
				frameLength, busyFrameLength);
		end
	endtask

	initial begin
		Clock = 1'b0;
		Resetn = 1'b0;
		Start = 1'b0;
		rngState = 32'h2cef_58de;
		errorCount = 0;
		repeat (4) @(posedge Clock);
		#1 Resetn = 1'b1;
		checkIdleAfterReset();
		testFlatGrey();
		testRandomFrame();
		testRowEdges();
		testExtremes();
		testStartWhileBusy();
		$display("Test run complete with %0d errors", errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CycleLimit) begin
			@(posedge Clock);
			cycleCount++;
		end
		$display("Run stopped after %0d cycles before the tests finished", cycleCount);
		$display("Errors found");
		$finish;
	end

endmodule

// File: tb/yuvToRgb_assertions.sv
`timescale 1ns/1ps

module yuvToRgb_assertions import convCtrlPkg::*; #(
	parameter int Width = 8,
	parameter int Height = 2,
	parameter logic [SramAddrWidth-1:0] RgbBase = '0
) (
	input logic Clock,
	input logic Resetn,
	input logic Busy,
	input logic Done,
	input logic SramWeN,
	input logic [SramAddrWidth-1:0] SramAddress
);

	localparam logic [SramAddrWidth-1:0] RgbEnd = RgbBase + SramAddrWidth'(3 * Width / 2 * Height);

	idleNoWrite: assert property (@(posedge Clock) disable iff (!Resetn) !Busy |-> SramWeN)
		else $error("SRAM write while the controller is idle");

	doneSingleCycle: assert property (@(posedge Clock) disable iff (!Resetn) Done |=> !Done)
		else $error("Done held high for more than one cycle");

	// Only the RGB region is ever written
	writeInRgbRegion: assert property (@(posedge Clock) disable iff (!Resetn)
		!SramWeN |-> (SramAddress >= RgbBase && SramAddress < RgbEnd))
		else $error("SRAM write at %h outside the RGB region", SramAddress);

endmodule

bind frameConvertCtrl yuvToRgb_assertions #(
	.Width(Width),
	.Height(Height),
	.RgbBase(RgbBase)
) yuvToRgbAssertions_i (
	.Clock(Clock),
	.Resetn(Resetn),
	.Busy(Busy),
	.Done(Done),
	.SramWeN(SramWeN),
	.SramAddress(SramAddress)
);

// File: tb/sramModel.sv
`timescale 1ns/1ps

module sramModel import convCtrlPkg::*; (
	input logic Clock,
	input logic [SramAddrWidth-1:0] Address,
	input logic [SramDataWidth-1:0] WriteData,
	input logic WeN,
	output logic [SramDataWidth-1:0] ReadData
);

	logic [SramDataWidth-1:0] memory [0:(1 << SramAddrWidth) - 1];
	logic [SramDataWidth-1:0] readStage;

	// Read data reaches the port two edges after its address
	always @(posedge Clock) begin
		readStage <= memory[Address];
		ReadData <= readStage;
		if (!WeN) begin
			memory[Address] = WriteData;
		end
	end

endmodule

// File: hw/yuvToRgbTop.sv
`timescale 1ns/1ps

module yuvToRgbTop import convCtrlPkg::*; #(
	parameter int Width = 8,
	parameter int Height = 2,
	parameter logic [SramAddrWidth-1:0] YBase = 18'd0,
	parameter logic [SramAddrWidth-1:0] UBase = 18'd64,
	parameter logic [SramAddrWidth-1:0] VBase = 18'd96,
	parameter logic [SramAddrWidth-1:0] RgbBase = 18'd128
) (
	input logic Clock,
	input logic Resetn,
	input logic Start,
	output logic Busy,
	output logic Done,
	output logic [SramAddrWidth-1:0] SramAddress,
	input logic [SramDataWidth-1:0] SramReadData,
	output logic [SramDataWidth-1:0] SramWriteData,
	output logic SramWeN
);

	logic uLoad, uShift, vLoad, vShift, pairValid, resultValid;
	logic [7:0] uSample, vSample, yEven, yOdd;
	logic [7:0] uEven, uOdd, vEven, vOdd;
	logic [7:0] redEven, greenEven, blueEven, redOdd, greenOdd, blueOdd;

	frameConvertCtrl #(
		.Width(Width),
		.Height(Height),
		.YBase(YBase),
		.UBase(UBase),
		.VBase(VBase),
		.RgbBase(RgbBase)
	) frameConvertCtrl_i (
		.Clock(Clock), .Resetn(Resetn), .Start(Start), .Busy(Busy), .Done(Done),
		.SramAddress(SramAddress), .SramReadData(SramReadData),
		.SramWriteData(SramWriteData), .SramWeN(SramWeN),
		.ULoad(uLoad), .UShift(uShift), .VLoad(vLoad), .VShift(vShift),
		.USample(uSample), .VSample(vSample),
		.PairValid(pairValid), .YEven(yEven), .YOdd(yOdd), .ResultValid(resultValid),
		.RedEven(redEven), .GreenEven(greenEven), .BlueEven(blueEven),
		.RedOdd(redOdd), .GreenOdd(greenOdd), .BlueOdd(blueOdd)
	);

	chromaUpsampler uUpsampler_i (
		.Clock(Clock), .Resetn(Resetn), .Load(uLoad), .Shift(uShift),
		.SampleIn(uSample), .EvenOut(uEven), .OddOut(uOdd)
	);

	chromaUpsampler vUpsampler_i (
		.Clock(Clock), .Resetn(Resetn), .Load(vLoad), .Shift(vShift),
		.SampleIn(vSample), .EvenOut(vEven), .OddOut(vOdd)
	);

	colorSpaceConverter colorSpaceConverter_i (
		.Clock(Clock), .Resetn(Resetn), .PairValid(pairValid),
		.YEven(yEven), .YOdd(yOdd), .UEven(uEven), .UOdd(uOdd),
		.VEven(vEven), .VOdd(vOdd), .ResultValid(resultValid),
		.RedEven(redEven), .GreenEven(greenEven), .BlueEven(blueEven),
		.RedOdd(redOdd), .GreenOdd(greenOdd), .BlueOdd(blueOdd)
	);

endmodule

// File: hw/frameConvertCtrl.sv
`timescale 1ns/1ps

module frameConvertCtrl import convCtrlPkg::*; #(
	parameter int Width = 8,
	parameter int Height = 2,
	parameter logic [SramAddrWidth-1:0] YBase = '0,
	parameter logic [SramAddrWidth-1:0] UBase = '0,
	parameter logic [SramAddrWidth-1:0] VBase = '0,
	parameter logic [SramAddrWidth-1:0] RgbBase = '0
) (
	input logic Clock,
	input logic Resetn,
	input logic Start,
	output logic Busy,
	output logic Done,
	output logic [SramAddrWidth-1:0] SramAddress,
	input logic [SramDataWidth-1:0] SramReadData,
	output logic [SramDataWidth-1:0] SramWriteData,
	output logic SramWeN,
	output logic ULoad,
	output logic UShift,
	output logic VLoad,
	output logic VShift,
	output logic [7:0] USample,
	output logic [7:0] VSample,
	output logic PairValid,
	output logic [7:0] YEven,
	output logic [7:0] YOdd,
	input logic ResultValid,
	input logic [7:0] RedEven,
	input logic [7:0] GreenEven,
	input logic [7:0] BlueEven,
	input logic [7:0] RedOdd,
	input logic [7:0] GreenOdd,
	input logic [7:0] BlueOdd
);

	localparam logic [SramAddrWidth-1:0] PairsPerRow = SramAddrWidth'(Width / 2);
	localparam logic [SramAddrWidth-1:0] ChromaWords = SramAddrWidth'(Width / 4);
	localparam logic [SramAddrWidth-1:0] LastRow = SramAddrWidth'(Height - 1);

	ConvState state;
	logic [2:0] liStep;
	logic [2:0] vStep;
	logic [2:0] slot;
	logic [1:0] wrPhase;
	logic [SramAddrWidth-1:0] rowIdx, yRow, cRow, pairIdx, chromaIdx, rgbAddr;
	logic [SramAddrWidth-1:0] readAddr;
	logic [SramDataWidth-1:0] yReg;
	logic [7:0] uHold, vHold;
	logic leadIn, chromaFetch, writeActive, uTakeWord, vTakeWord;

	assign leadIn = (state == StLeadInRead) || (state == StLeadInFill);
	assign vStep = liStep - 3'd1;
	assign chromaIdx = (pairIdx >> 1) + SramAddrWidth'(2);
	// Even pairs fetch a new chroma word while one remains in the row
	assign chromaFetch = !pairIdx[0] && (chromaIdx < ChromaWords);

	assign Busy = (state != StIdle) && (state != StDone);
	assign Done = (state == StDone);
	assign PairValid = (state == StPairFetch) && (slot == 3'd0);
	assign YEven = yReg[15:8];
	assign YOdd = yReg[7:0];

	// Lead-in feeds each plane load, hold, high, hold; V runs one cycle behind U
	assign uTakeWord = (leadIn && (liStep == 3'd2 || liStep == 3'd4))
		|| (state == StPairWrite && slot == 3'd4 && chromaFetch);
	assign vTakeWord = (leadIn && (vStep == 3'd2 || vStep == 3'd4))
		|| (state == StPairWrite && slot == 3'd5 && chromaFetch);
	assign ULoad = leadIn && (liStep == 3'd2);
	assign VLoad = leadIn && (vStep == 3'd2);
	assign UShift = (leadIn && liStep >= 3'd3 && liStep <= 3'd5)
		|| (state == StPairWrite && slot == 3'd4);
	assign VShift = (leadIn && vStep >= 3'd3 && vStep <= 3'd5)
		|| (state == StPairWrite && slot == 3'd5);
	// Past the row end the held last sample keeps going in
	assign USample = uTakeWord ? SramReadData[15:8] : uHold;
	assign VSample = vTakeWord ? SramReadData[15:8] : vHold;

	always_comb begin
		readAddr = YBase + yRow;
		case (state)
			StLeadInRead: begin
				case (liStep)
					3'd0: readAddr = UBase + cRow;
					3'd1: readAddr = VBase + cRow;
					3'd2: readAddr = UBase + cRow + SramAddrWidth'(1);
					3'd3: readAddr = VBase + cRow + SramAddrWidth'(1);
					default: readAddr = YBase + yRow;
				endcase
			end
			StPairFetch: begin
				if (slot == 3'd1) begin
					readAddr = YBase + yRow + pairIdx + SramAddrWidth'(1);
				end else if (slot == 3'd2) begin
					readAddr = UBase + cRow + chromaIdx;
				end
			end
			StPairWrite: begin
				if (slot == 3'd3) begin
					readAddr = VBase + cRow + chromaIdx;
				end
			end
			default: ;
		endcase
	end

	// Three packed writes start with ResultValid
	assign writeActive = ResultValid || (wrPhase != 2'd0);
	assign SramWeN = !writeActive;
	assign SramAddress = writeActive ? rgbAddr : readAddr;

	always_comb begin
		case (wrPhase)
			2'd1: SramWriteData = {BlueEven, RedOdd};
			2'd2: SramWriteData = {GreenOdd, BlueOdd};
			default: SramWriteData = {RedEven, GreenEven};
		endcase
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= StIdle;
			liStep <= 3'd0;
			slot <= 3'd0;
			wrPhase <= 2'd0;
			rowIdx <= '0;
			yRow <= '0;
			cRow <= '0;
			pairIdx <= '0;
			rgbAddr <= '0;
		end else begin
			if (ResultValid) begin
				wrPhase <= 2'd1;
			end else if (wrPhase == 2'd1) begin
				wrPhase <= 2'd2;
			end else begin
				wrPhase <= 2'd0;
			end
			if (writeActive) begin
				rgbAddr <= rgbAddr + SramAddrWidth'(1);
			end

			case (state)
				StIdle: begin
					if (Start) begin
						state <= StLeadInRead;
						liStep <= 3'd0;
						rowIdx <= '0;
						yRow <= '0;
						cRow <= '0;
						rgbAddr <= RgbBase;
					end
				end
				StLeadInRead: begin
					liStep <= liStep + 3'd1;
					if (liStep == 3'd4) begin
						state <= StLeadInFill;
					end
				end
				StLeadInFill: begin
					liStep <= liStep + 3'd1;
					if (liStep == 3'd6) begin
						state <= StPairFetch;
						slot <= 3'd0;
						pairIdx <= '0;
					end
				end
				StPairFetch: begin
					slot <= slot + 3'd1;
					if (slot == 3'd2) begin
						state <= StPairWrite;
					end
				end
				StPairWrite: begin
					if (slot == 3'd5) begin
						slot <= 3'd0;
						if (pairIdx == PairsPerRow - SramAddrWidth'(1)) begin
							state <= StLeadOut;
						end else begin
							state <= StPairFetch;
							pairIdx <= pairIdx + SramAddrWidth'(1);
						end
					end else begin
						slot <= slot + 3'd1;
					end
				end
				StLeadOut: begin
					if (rowIdx == LastRow) begin
						state <= StDone;
					end else begin
						state <= StLeadInRead;
						liStep <= 3'd0;
						rowIdx <= rowIdx + SramAddrWidth'(1);
						yRow <= yRow + PairsPerRow;
						cRow <= cRow + ChromaWords;
					end
				end
				default: state <= StIdle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (uTakeWord) begin
			uHold <= SramReadData[7:0];
		end
		if (vTakeWord) begin
			vHold <= SramReadData[7:0];
		end
		// Y word lands two cycles after its read
		if ((leadIn && liStep == 3'd6) || (state == StPairWrite && slot == 3'd3)) begin
			yReg <= SramReadData;
		end
	end

endmodule

// File: hw/colorSpaceConverter.sv
`timescale 1ns/1ps

module colorSpaceConverter import colorPkg::*; (
	input logic Clock,
	input logic Resetn,
	input logic PairValid,
	input logic [7:0] YEven,
	input logic [7:0] YOdd,
	input logic [7:0] UEven,
	input logic [7:0] UOdd,
	input logic [7:0] VEven,
	input logic [7:0] VOdd,
	output logic ResultValid,
	output logic [7:0] RedEven,
	output logic [7:0] GreenEven,
	output logic [7:0] BlueEven,
	output logic [7:0] RedOdd,
	output logic [7:0] GreenOdd,
	output logic [7:0] BlueOdd
);

	CscPhase phase;
	CscPhase activePhase;
	logic [7:0] yEvenQ, yOddQ, uEvenQ, uOddQ, vEvenQ, vOddQ;
	logic [7:0] yOp, uOp, vOp;
	logic [7:0] redEvenQ, greenEvenQ, blueEvenQ, redOddQ, blueOddQ;
	logic signed [31:0] prodA, prodB, prodC;
	logic [7:0] redNow, greenNow, blueNow;

	function automatic logic [7:0] clipChannel(input logic signed [31:0] value);
		logic signed [31:0] scaled;
		scaled = value >>> 16;
		if (scaled < 0) begin
			return 8'd0;
		end else if (scaled > 255) begin
			return 8'd255;
		end
		return scaled[7:0];
	endfunction

	// The even red/blue phase runs in the PairValid cycle on the raw inputs
	assign activePhase = PairValid ? CscEvenRb : phase;

	always_comb begin
		case (activePhase)
			CscEvenRb: begin
				yOp = YEven;
				uOp = UEven;
				vOp = VEven;
			end
			CscEvenG: begin
				yOp = yEvenQ;
				uOp = uEvenQ;
				vOp = vEvenQ;
			end
			default: begin
				yOp = yOddQ;
				uOp = uOddQ;
				vOp = vOddQ;
			end
		endcase
	end

	// Three shared multipliers
	always_comb begin
		prodA = CoefY * (int'(yOp) - LumaOffset);
		if (activePhase == CscEvenRb || activePhase == CscOddRb) begin
			prodB = CoefBU * (int'(uOp) - ChromaOffset);
			prodC = CoefRV * (int'(vOp) - ChromaOffset);
		end else begin
			prodB = CoefGU * (int'(uOp) - ChromaOffset);
			prodC = CoefGV * (int'(vOp) - ChromaOffset);
		end
		redNow = clipChannel(prodA + prodC);
		blueNow = clipChannel(prodA + prodB);
		greenNow = clipChannel(prodA - prodB - prodC);
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			phase <= CscIdle;
			ResultValid <= 1'b0;
		end else begin
			ResultValid <= (activePhase == CscOddG);
			case (activePhase)
				CscEvenRb: phase <= CscEvenG;
				CscEvenG: phase <= CscOddRb;
				CscOddRb: phase <= CscOddG;
				default: phase <= CscIdle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (PairValid) begin
			yEvenQ <= YEven;
			yOddQ <= YOdd;
			uEvenQ <= UEven;
			uOddQ <= UOdd;
			vEvenQ <= VEven;
			vOddQ <= VOdd;
		end
		case (activePhase)
			CscEvenRb: begin
				redEvenQ <= redNow;
				blueEvenQ <= blueNow;
			end
			CscEvenG: greenEvenQ <= greenNow;
			CscOddRb: begin
				redOddQ <= redNow;
				blueOddQ <= blueNow;
			end
			CscOddG: begin
				// Whole pair moves to the outputs at once
				RedEven <= redEvenQ;
				GreenEven <= greenEvenQ;
				BlueEven <= blueEvenQ;
				RedOdd <= redOddQ;
				BlueOdd <= blueOddQ;
				GreenOdd <= greenNow;
			end
			default: ;
		endcase
	end

endmodule

// File: hw/chromaUpsampler.sv
`timescale 1ns/1ps

module chromaUpsampler import colorPkg::*; (
	input logic Clock,
	input logic Resetn,
	input logic Load,
	input logic Shift,
	input logic [7:0] SampleIn,
	output logic [7:0] EvenOut,
	output logic [7:0] OddOut
);

	logic [7:0] taps [0:5];
	logic [7:0] nextTaps [0:5];
	logic [8:0] sumFar;
	logic [8:0] sumMid;
	logic [8:0] sumNear;
	logic signed [31:0] acc;
	logic signed [31:0] shifted;
	logic [7:0] oddNext;

	// Window after this cycle's load or shift
	always_comb begin
		for (int i = 0; i < 5; i++) begin
			nextTaps[i] = Load ? SampleIn : taps[i + 1];
		end
		nextTaps[5] = SampleIn;
	end

	// Symmetric filter on the new window, centred between taps 2 and 3
	always_comb begin
		sumFar = {1'b0, nextTaps[0]} + {1'b0, nextTaps[5]};
		sumMid = {1'b0, nextTaps[1]} + {1'b0, nextTaps[4]};
		sumNear = {1'b0, nextTaps[2]} + {1'b0, nextTaps[3]};
		acc = FirTapFar * int'(sumFar) - FirTapMid * int'(sumMid)
			+ FirTapNear * int'(sumNear) + FirRound;
		shifted = acc >>> 8;
		if (shifted < 0) begin
			oddNext = 8'd0;
		end else if (shifted > 255) begin
			oddNext = 8'd255;
		end else begin
			oddNext = shifted[7:0];
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			for (int i = 0; i < 6; i++) begin
				taps[i] <= 8'd0;
			end
			OddOut <= 8'd0;
		end else if (Load || Shift) begin
			taps <= nextTaps;
			OddOut <= oddNext;
		end
	end

	assign EvenOut = taps[2];

endmodule

// File: hw/convCtrlPkg.sv
package convCtrlPkg;

	localparam int SramAddrWidth = 18;
	localparam int SramDataWidth = 16;

	// Row sequence of the frame controller
	typedef enum logic [2:0] {
		StIdle,
		StLeadInRead,
		StLeadInFill,
		StPairFetch,
		StPairWrite,
		StLeadOut,
		StDone
	} ConvState;

endpackage

// File: hw/colorPkg.sv
package colorPkg;

	// Interpolation weights for the even-sample pairs around an odd sample
	localparam int FirTapNear = 159;
	localparam int FirTapMid = 52;
	localparam int FirTapFar = 21;
	localparam int FirRound = 128;

	// 16-bit fixed-point conversion gains
	localparam int CoefY = 76284;
	localparam int CoefRV = 104595;
	localparam int CoefGU = 25624;
	localparam int CoefGV = 53281;
	localparam int CoefBU = 132251;

	localparam int LumaOffset = 16;
	localparam int ChromaOffset = 128;

	typedef enum logic [2:0] {
		CscIdle,
		CscEvenRb,
		CscEvenG,
		CscOddRb,
		CscOddG
	} CscPhase;

endpackage
